// ==== src/cache_pkg.sv ====
// cache geometry localparams and the refill FSM state type
package cache_pkg;

  // byte address layout: {tag, index, byte offset}
  localparam int ADDR_W = 32;
  localparam int OFF_W  = 6;                        // 64-byte lines
  localparam int IDX_W  = 4;
  localparam int TAG_W  = ADDR_W - IDX_W - OFF_W;   // 22

  // line geometry
  localparam int NUM_LINES      = 1 << IDX_W;       // 16 lines
  localparam int WORDS_PER_LINE = 16;               // also the burst length
  localparam int WORD_OFF_W     = 4;                // word index in a line

  // memory master burstcount width
  localparam int BURST_W = 5;

  // refill controller states
  typedef enum logic [1:0] {
    ST_IDLE      = 2'd0,  // serving hits, waiting for a miss
    ST_WRITEBACK = 2'd1,  // dirty victim going out
    ST_REFILL    = 2'd2   // missing line coming in
  } refill_state_e;

endpackage

// ==== src/cache_line.sv ====
// cache_line: data words, tag, valid and dirty of one line, two lookup ports, one write port
`timescale 1ns/1ps

module cache_line (
  input  logic                             clk,
  input  logic                             rst_n,

  // port A lookup
  input  logic [cache_pkg::TAG_W-1:0]      tag_a_i,
  input  logic [cache_pkg::WORD_OFF_W-1:0] woff_a_i,
  output logic                             hit_a_o,
  output logic [31:0]                      data_a_o,

  // port B lookup
  input  logic [cache_pkg::TAG_W-1:0]      tag_b_i,
  input  logic [cache_pkg::WORD_OFF_W-1:0] woff_b_i,
  output logic                             hit_b_o,
  output logic [31:0]                      data_b_o,

  // shared write port
  input  logic                             we_i,
  input  logic [cache_pkg::WORD_OFF_W-1:0] wr_woff_i,
  input  logic [31:0]                      wr_data_i,
  input  logic [3:0]                       wr_be_i,
  input  logic                             fill_i,       // refill beat, not a cpu write
  input  logic                             fill_last_i,
  input  logic [cache_pkg::TAG_W-1:0]      fill_tag_i,

  // victim side
  input  logic [cache_pkg::WORD_OFF_W-1:0] lkup_woff_i,
  output logic [31:0]                      lkup_data_o,
  output logic                             dirty_o,
  output logic [cache_pkg::TAG_W-1:0]      tag_o
);

  logic [31:0]                 words [cache_pkg::WORDS_PER_LINE];
  logic [cache_pkg::TAG_W-1:0] tag_q;
  logic                        valid_q;
  logic                        dirty_q;

  assign hit_a_o     = valid_q && (tag_q == tag_a_i);
  assign hit_b_o     = valid_q && (tag_q == tag_b_i);
  assign data_a_o    = words[woff_a_i];
  assign data_b_o    = words[woff_b_i];
  assign lkup_data_o = words[lkup_woff_i];
  assign dirty_o     = dirty_q;
  assign tag_o       = tag_q;

  // data array, byte merge on cpu writes, whole word on fills
  always_ff @(posedge clk) begin
    if (we_i) begin
      for (int b = 0; b < 4; b++) begin
        if (fill_i || wr_be_i[b]) begin
          words[wr_woff_i][8*b +: 8] <= wr_data_i[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (we_i && fill_i && fill_last_i) begin
      tag_q <= fill_tag_i;  // new owner of the line
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
      dirty_q <= 1'b0;
    end else if (we_i) begin
      if (!fill_i) begin
        dirty_q <= 1'b1;  // write hit
      end else if (fill_last_i) begin
        valid_q <= 1'b1;
        dirty_q <= 1'b0;  // fresh copy of memory
      end
    end
  end

endmodule

// ==== src/cache_refill.sv ====
// cache_refill: miss FSM driving the write-back burst and the refill burst on the memory master
`timescale 1ns/1ps

module cache_refill (
  input  logic                             clk,
  input  logic                             rst_n,

  // miss requests from the ports
  input  logic                             miss_a_i,
  input  logic                             miss_b_i,
  input  logic [cache_pkg::ADDR_W-1:0]     addr_a_i,
  input  logic [cache_pkg::ADDR_W-1:0]     addr_b_i,

  // victim line, selected by miss_idx_o
  input  logic                             victim_dirty_i,
  input  logic [cache_pkg::TAG_W-1:0]      victim_tag_i,
  input  logic [31:0]                      lkup_data_i,

  // to the line array
  output cache_pkg::refill_state_e         state_o,
  output logic [cache_pkg::IDX_W-1:0]      miss_idx_o,
  output logic [cache_pkg::WORD_OFF_W-1:0] fill_woff_o,
  output logic                             fill_we_o,
  output logic                             fill_last_o,
  output logic [cache_pkg::TAG_W-1:0]      fill_tag_o,

  // memory master
  output logic [cache_pkg::ADDR_W-1:0]     m_address_o,
  output logic                             m_read_o,
  output logic                             m_write_o,
  output logic [31:0]                      m_writedata_o,
  input  logic [31:0]                      m_readdata_i,
  input  logic                             m_waitrequest_i,
  input  logic                             m_readdatavalid_i
);

  localparam logic [cache_pkg::WORD_OFF_W-1:0] LAST_WORD =
    cache_pkg::WORD_OFF_W'(cache_pkg::WORDS_PER_LINE - 1);

  cache_pkg::refill_state_e           state_q;
  logic [cache_pkg::WORD_OFF_W-1:0]   cnt_q;
  logic [cache_pkg::TAG_W-1:0]        tag_q;
  logic [cache_pkg::IDX_W-1:0]        idx_q;
  logic [cache_pkg::TAG_W-1:0]        req_tag;
  logic [cache_pkg::IDX_W-1:0]        req_idx;
  logic                               req_any;

  // port A has priority, B keeps missing until its turn
  assign req_any = miss_a_i || miss_b_i;
  assign req_tag = miss_a_i ? addr_a_i[cache_pkg::ADDR_W-1 -: cache_pkg::TAG_W]
                            : addr_b_i[cache_pkg::ADDR_W-1 -: cache_pkg::TAG_W];
  assign req_idx = miss_a_i ? addr_a_i[cache_pkg::OFF_W +: cache_pkg::IDX_W]
                            : addr_b_i[cache_pkg::OFF_W +: cache_pkg::IDX_W];

  // victim must be visible in the same cycle the miss is taken
  assign miss_idx_o = (state_q == cache_pkg::ST_IDLE) ? req_idx : idx_q;

  assign state_o       = state_q;
  assign fill_woff_o   = cnt_q;
  assign fill_tag_o    = tag_q;
  assign fill_we_o     = (state_q == cache_pkg::ST_REFILL) && m_readdatavalid_i;
  assign fill_last_o   = fill_we_o && (cnt_q == LAST_WORD);
  assign m_writedata_o = lkup_data_i;  // follows cnt_q, moves only after an accepted beat

  always_ff @(posedge clk) begin
    if (state_q == cache_pkg::ST_IDLE && req_any) begin
      tag_q <= req_tag;
      idx_q <= req_idx;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= cache_pkg::ST_IDLE;
      cnt_q       <= '0;
      m_address_o <= '0;
      m_read_o    <= 1'b0;
      m_write_o   <= 1'b0;
    end else begin
      case (state_q)
        cache_pkg::ST_IDLE: begin
          cnt_q <= '0;
          if (req_any) begin
            if (victim_dirty_i) begin
              state_q     <= cache_pkg::ST_WRITEBACK;
              m_address_o <= {victim_tag_i, req_idx, cache_pkg::OFF_W'(0)};
              m_write_o   <= 1'b1;
            end else begin
              state_q     <= cache_pkg::ST_REFILL;
              m_address_o <= {req_tag, req_idx, cache_pkg::OFF_W'(0)};
              m_read_o    <= 1'b1;
            end
          end
        end

        cache_pkg::ST_WRITEBACK: begin
          if (!m_waitrequest_i) begin
            if (cnt_q == LAST_WORD) begin
              cnt_q       <= '0;
              m_write_o   <= 1'b0;
              state_q     <= cache_pkg::ST_REFILL;
              m_address_o <= {tag_q, idx_q, cache_pkg::OFF_W'(0)};
              m_read_o    <= 1'b1;
            end else begin
              cnt_q <= cnt_q + 1'b1;
            end
          end
        end

        cache_pkg::ST_REFILL: begin
          if (m_read_o && !m_waitrequest_i) begin
            m_read_o <= 1'b0;  // one command per burst
          end
          if (m_readdatavalid_i) begin
            if (cnt_q == LAST_WORD) begin
              cnt_q   <= '0;
              state_q <= cache_pkg::ST_IDLE;
            end else begin
              cnt_q <= cnt_q + 1'b1;
            end
          end
        end

        default: begin
          state_q <= cache_pkg::ST_IDLE;
        end
      endcase
    end
  end

endmodule

// ==== src/cache_top.sv ====
// cache_top: address split, line array, hit and waitrequest logic, write port mux, refill FSM
`timescale 1ns/1ps

module cache_top (
  input  logic                          clk,
  input  logic                          rst_n,

  // port A, read/write
  input  logic [cache_pkg::ADDR_W-1:0]  a_address_i,
  input  logic                          a_read_i,
  input  logic                          a_write_i,
  input  logic [31:0]                   a_writedata_i,
  input  logic [3:0]                    a_byteenable_i,
  output logic [31:0]                   a_readdata_o,
  output logic                          a_waitrequest_o,

  // port B, read only
  input  logic [cache_pkg::ADDR_W-1:0]  b_address_i,
  input  logic                          b_read_i,
  output logic [31:0]                   b_readdata_o,
  output logic                          b_waitrequest_o,

  // memory burst master
  output logic [cache_pkg::ADDR_W-1:0]  m_address_o,
  output logic [cache_pkg::BURST_W-1:0] m_burstcount_o,
  output logic                          m_read_o,
  output logic                          m_write_o,
  output logic [31:0]                   m_writedata_o,
  input  logic [31:0]                   m_readdata_i,
  input  logic                          m_waitrequest_i,
  input  logic                          m_readdatavalid_i
);

  logic [cache_pkg::TAG_W-1:0]      a_tag;
  logic [cache_pkg::IDX_W-1:0]      a_idx;
  logic [cache_pkg::WORD_OFF_W-1:0] a_woff;
  logic [cache_pkg::TAG_W-1:0]      b_tag;
  logic [cache_pkg::IDX_W-1:0]      b_idx;
  logic [cache_pkg::WORD_OFF_W-1:0] b_woff;

  // per-line results
  logic [cache_pkg::NUM_LINES-1:0]  hit_a_v;
  logic [cache_pkg::NUM_LINES-1:0]  hit_b_v;
  logic [cache_pkg::NUM_LINES-1:0]  dirty_v;
  logic [cache_pkg::NUM_LINES-1:0]  we_v;
  logic [31:0]                      data_a_arr [cache_pkg::NUM_LINES];
  logic [31:0]                      data_b_arr [cache_pkg::NUM_LINES];
  logic [31:0]                      lkup_arr   [cache_pkg::NUM_LINES];
  logic [cache_pkg::TAG_W-1:0]      tag_arr    [cache_pkg::NUM_LINES];

  // refill side
  cache_pkg::refill_state_e         state;
  logic [cache_pkg::IDX_W-1:0]      miss_idx;
  logic [cache_pkg::WORD_OFF_W-1:0] fill_woff;
  logic                             fill_we;
  logic                             fill_last;
  logic [cache_pkg::TAG_W-1:0]      fill_tag;
  logic                             refilling;
  logic                             busy;

  // muxed write port
  logic [cache_pkg::WORD_OFF_W-1:0] wr_woff;
  logic [31:0]                      wr_data;
  logic [3:0]                       wr_be;

  logic hit_a;
  logic hit_b;
  logic miss_a;
  logic miss_b;

  assign a_tag  = a_address_i[cache_pkg::ADDR_W-1 -: cache_pkg::TAG_W];
  assign a_idx  = a_address_i[cache_pkg::OFF_W +: cache_pkg::IDX_W];
  assign a_woff = a_address_i[2 +: cache_pkg::WORD_OFF_W];
  assign b_tag  = b_address_i[cache_pkg::ADDR_W-1 -: cache_pkg::TAG_W];
  assign b_idx  = b_address_i[cache_pkg::OFF_W +: cache_pkg::IDX_W];
  assign b_woff = b_address_i[2 +: cache_pkg::WORD_OFF_W];

  assign busy      = (state != cache_pkg::ST_IDLE);
  assign refilling = (state == cache_pkg::ST_REFILL);

  // the line under write-back or refill never hits, and a
  // cpu write waits while the refill owns the write port
  assign hit_a = hit_a_v[a_idx] && !(busy && (a_idx == miss_idx))
                 && !(a_write_i && refilling);
  assign hit_b = hit_b_v[b_idx] && !(busy && (b_idx == miss_idx));

  assign miss_a = (a_read_i || a_write_i) && !hit_a;
  assign miss_b = b_read_i && !hit_b;

  assign a_waitrequest_o = miss_a;
  assign b_waitrequest_o = miss_b;
  assign a_readdata_o    = data_a_arr[a_idx];
  assign b_readdata_o    = data_b_arr[b_idx];

  assign m_burstcount_o = cache_pkg::BURST_W'(cache_pkg::WORDS_PER_LINE);

  assign wr_woff = refilling ? fill_woff    : a_woff;
  assign wr_data = refilling ? m_readdata_i : a_writedata_i;
  assign wr_be   = refilling ? 4'hf         : a_byteenable_i;

  for (genvar i = 0; i < cache_pkg::NUM_LINES; i++) begin : g_line
    assign we_v[i] = refilling
                     ? (fill_we && (miss_idx == cache_pkg::IDX_W'(i)))
                     : (a_write_i && hit_a && (a_idx == cache_pkg::IDX_W'(i)));

    cache_line u_line (
      .clk         (clk),
      .rst_n       (rst_n),
      .tag_a_i     (a_tag),
      .woff_a_i    (a_woff),
      .hit_a_o     (hit_a_v[i]),
      .data_a_o    (data_a_arr[i]),
      .tag_b_i     (b_tag),
      .woff_b_i    (b_woff),
      .hit_b_o     (hit_b_v[i]),
      .data_b_o    (data_b_arr[i]),
      .we_i        (we_v[i]),
      .wr_woff_i   (wr_woff),
      .wr_data_i   (wr_data),
      .wr_be_i     (wr_be),
      .fill_i      (refilling),
      .fill_last_i (fill_last),
      .fill_tag_i  (fill_tag),
      .lkup_woff_i (fill_woff),     // write-back walks the same counter
      .lkup_data_o (lkup_arr[i]),
      .dirty_o     (dirty_v[i]),
      .tag_o       (tag_arr[i])
    );
  end

  cache_refill u_refill (
    .clk               (clk),
    .rst_n             (rst_n),
    .miss_a_i          (miss_a),
    .miss_b_i          (miss_b),
    .addr_a_i          (a_address_i),
    .addr_b_i          (b_address_i),
    .victim_dirty_i    (dirty_v[miss_idx]),
    .victim_tag_i      (tag_arr[miss_idx]),
    .lkup_data_i       (lkup_arr[miss_idx]),
    .state_o           (state),
    .miss_idx_o        (miss_idx),
    .fill_woff_o       (fill_woff),
    .fill_we_o         (fill_we),
    .fill_last_o       (fill_last),
    .fill_tag_o        (fill_tag),
    .m_address_o       (m_address_o),
    .m_read_o          (m_read_o),
    .m_write_o         (m_write_o),
    .m_writedata_o     (m_writedata_o),
    .m_readdata_i      (m_readdata_i),
    .m_waitrequest_i   (m_waitrequest_i),
    .m_readdatavalid_i (m_readdatavalid_i)
  );

endmodule

// ==== dv/mem_model.sv ====
// mem_model: Avalon burst memory with random waitrequest and fixed read latency
`timescale 1ns/1ps

module mem_model (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [cache_pkg::ADDR_W-1:0]  address_i,
  input  logic [cache_pkg::BURST_W-1:0] burstcount_i,
  input  logic                          read_i,
  input  logic                          write_i,
  input  logic [31:0]                   writedata_i,
  output logic [31:0]                   readdata_o,
  output logic                          waitrequest_o,
  output logic                          readdatavalid_o
);

  localparam int RD_LATENCY = 3;

  logic [31:0]                   mem [int unsigned];  // sparse, word addressed
  int                            wr_beat;
  logic                          rd_cmd;              // read accepted at the last edge
  logic [cache_pkg::ADDR_W-1:0]  rd_base;
  logic [cache_pkg::BURST_W-1:0] rd_len;

  function automatic int unsigned beat_key(input logic [31:0] base, input int beat);
    return {2'b00, base[31:2]} + $unsigned(beat);
  endfunction

  // never written words read back as a pattern of their own address
  function automatic logic [31:0] word_at(input int unsigned key);
    if (mem.exists(key)) begin
      return mem[key];
    end
    return key ^ 32'hA5A5_0000;
  endfunction

  // command side, sampled on the rising edge
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_beat <= 0;
      rd_cmd  <= 1'b0;
    end else begin
      rd_cmd <= read_i && !waitrequest_o;
      if (read_i && !waitrequest_o) begin
        rd_base <= address_i;
        rd_len  <= burstcount_i;
      end
      if (write_i && !waitrequest_o) begin
        mem[beat_key(address_i, wr_beat)] = writedata_i;
        wr_beat <= (wr_beat == int'(burstcount_i) - 1) ? 0 : wr_beat + 1;
      end
    end
  end

  // response side, driven on the falling edge
  initial begin
    int          delay;
    int          beat;
    bit          busy;
    readdata_o      = '0;
    waitrequest_o   = 1'b0;
    readdatavalid_o = 1'b0;
    void'($urandom(16330));
    busy            = 1'b0;
    delay           = 0;
    beat            = 0;
    forever begin
      @(negedge clk);
      waitrequest_o   = ($urandom_range(3, 0) == 0);  // roughly one cycle in four
      readdatavalid_o = 1'b0;
      if (!rst_n) begin
        busy = 1'b0;
      end else if (rd_cmd && !busy) begin
        busy  = 1'b1;
        delay = RD_LATENCY - 2;
        beat  = 0;
      end else if (busy) begin
        if (delay > 0) begin
          delay--;
        end else begin
          readdatavalid_o = 1'b1;
          readdata_o      = word_at(beat_key(rd_base, beat));
          beat++;
          if (beat == int'(rd_len)) begin
            busy = 1'b0;
          end
        end
      end
    end
  end

endmodule

// ==== dv/tb_cache.sv ====
// tb_cache: table-driven testbench for cache_top with shadow memory, checks and timeout
`timescale 1ns/1ps

module tb_cache;

  typedef enum logic [1:0] {OP_AR, OP_AW, OP_BR, OP_ABR} op_e;

  localparam int          CYCLES_PER_TEST = 200;
  localparam logic [31:0] INIT_XOR        = 32'hA5A5_0000;

  logic        clk = 1'b0;
  logic        rst_n;
  logic [31:0] a_address, a_writedata, a_readdata, b_address, b_readdata;
  logic        a_read, a_write, a_waitrequest, b_read, b_waitrequest;
  logic [3:0]  a_byteenable;
  logic [31:0] m_address, m_writedata, m_readdata;
  logic [4:0]  m_burstcount;
  logic        m_read, m_write, m_waitrequest, m_readdatavalid;

  // stimulus table, one entry per index
  string       t_name [$];
  op_e         t_op [$];
  logic [31:0] t_addr_a [$];
  logic [31:0] t_addr_b [$];
  logic [31:0] t_wdata [$];
  logic [3:0]  t_be [$];
  bit          t_hit [$];  // 1 for a hit, 0 for a miss that has to wait

  logic [31:0] shadow [int unsigned];
  int          cycle_cnt   = 0;
  int          cycle_limit = 0;
  int          test_errs;
  int          n_pass   = 0;
  int          n_fail   = 0;
  int          bus_errs = 0;

  always #2 clk = ~clk;

  cache_top uut (
    .clk (clk), .rst_n (rst_n),
    .a_address_i (a_address), .a_read_i (a_read), .a_write_i (a_write),
    .a_writedata_i (a_writedata), .a_byteenable_i (a_byteenable),
    .a_readdata_o (a_readdata), .a_waitrequest_o (a_waitrequest),
    .b_address_i (b_address), .b_read_i (b_read),
    .b_readdata_o (b_readdata), .b_waitrequest_o (b_waitrequest),
    .m_address_o (m_address), .m_burstcount_o (m_burstcount), .m_read_o (m_read),
    .m_write_o (m_write), .m_writedata_o (m_writedata), .m_readdata_i (m_readdata),
    .m_waitrequest_i (m_waitrequest), .m_readdatavalid_i (m_readdatavalid)
  );

  mem_model u_mem (
    .clk (clk), .rst_n (rst_n),
    .address_i (m_address), .burstcount_i (m_burstcount), .read_i (m_read),
    .write_i (m_write), .writedata_i (m_writedata), .readdata_o (m_readdata),
    .waitrequest_o (m_waitrequest), .readdatavalid_o (m_readdatavalid)
  );

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
      $display("timeout: no finish within %0d cycles", cycle_limit);
      $display("Test failed");
      $finish;
    end
  end

  // every burst on the memory master is one full line
  always @(negedge clk) begin
    if (rst_n && (m_read || m_write)) begin
      assert (m_burstcount == 5'd16) else begin
        $display("memory master issued a burst of %0d beats instead of 16", m_burstcount);
        bus_errs++;
      end
    end
  end

  function automatic logic [31:0] expected_word(input logic [31:0] addr);
    int unsigned key;
    key = {2'b00, addr[31:2]};
    if (shadow.exists(key)) begin
      return shadow[key];
    end
    return key ^ INIT_XOR;
  endfunction

  task automatic shadow_write(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] be);
    logic [31:0] w;
    w = expected_word(addr);
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        w[8*b +: 8] = data[8*b +: 8];
      end
    end
    shadow[{2'b00, addr[31:2]}] = w;
  endtask

  task automatic add_test(input string name, input op_e op, input logic [31:0] addr_a,
                          input logic [31:0] addr_b, input logic [31:0] wdata,
                          input logic [3:0] be, input bit hit);
    t_name.push_back(name);
    t_op.push_back(op);
    t_addr_a.push_back(addr_a);
    t_addr_b.push_back(addr_b);
    t_wdata.push_back(wdata);
    t_be.push_back(be);
    t_hit.push_back(hit);
  endtask

  task automatic check_word(input string name, input string port, input logic [31:0] exp,
                            input logic [31:0] got);
    assert (got == exp) else begin
      $display("ERR %s port %s: expected %h, actual %h", name, port, exp, got);
      test_errs++;
    end
  endtask

  task automatic report_test(input string name);
    if (test_errs == 0) begin
      n_pass++;
      $display("PASS %s", name);
    end else begin
      n_fail++;
      $display("FAIL %s (%0d errors)", name, test_errs);
    end
  endtask

  task automatic check_reset_state();
    test_errs = 0;
    assert (m_read == 1'b0 && m_write == 1'b0) else begin
      $display("memory master is busy right after reset");
      test_errs++;
    end
    assert (a_waitrequest == 1'b0 && b_waitrequest == 1'b0) else begin
      $display("an idle port holds waitrequest high after reset");
      test_errs++;
    end
    report_test("reset_idle");
  endtask

  // called on a falling edge, returns on a falling edge
  task automatic run_test(input int t);
    bit          a_act;
    bit          b_act;
    bit          a_done;
    bit          b_done;
    int          waits;
    logic [31:0] exp_a;
    logic [31:0] exp_b;
    logic [31:0] got_a;
    logic [31:0] got_b;
    test_errs    = 0;
    a_act        = (t_op[t] != OP_BR);
    b_act        = (t_op[t] == OP_BR) || (t_op[t] == OP_ABR);
    exp_a        = expected_word(t_addr_a[t]);
    exp_b        = expected_word(t_addr_b[t]);
    got_a        = '0;
    got_b        = '0;
    a_address    = t_addr_a[t];
    a_read       = a_act && (t_op[t] != OP_AW);
    a_write      = (t_op[t] == OP_AW);
    a_writedata  = t_wdata[t];
    a_byteenable = t_be[t];
    b_address    = t_addr_b[t];
    b_read       = b_act;
    a_done       = !a_act;
    b_done       = !b_act;
    waits        = 0;
    while (!(a_done && b_done)) begin
      #1;  // mid-cycle, outputs settled
      if (!a_done && !a_waitrequest) begin
        got_a  = a_readdata;
        a_done = 1'b1;
      end
      if (!b_done && !b_waitrequest) begin
        got_b  = b_readdata;
        b_done = 1'b1;
      end
      if (!(a_done && b_done)) begin
        waits++;
      end
      @(negedge clk);
      if (a_done) begin
        a_read  = 1'b0;
        a_write = 1'b0;
      end
      if (b_done) begin
        b_read = 1'b0;
      end
    end
    if (t_op[t] == OP_AW) begin
      shadow_write(t_addr_a[t], t_wdata[t], t_be[t]);
    end else if (a_act) begin
      check_word(t_name[t], "A", exp_a, got_a);
    end
    if (b_act) begin
      check_word(t_name[t], "B", exp_b, got_b);
    end
    if (t_hit[t]) begin
      assert (waits == 0) else begin
        $display("%s: waitrequest rose on an access to a cached line", t_name[t]);
        test_errs++;
      end
    end else begin
      assert (waits > 0) else begin
        $display("%s: access to an uncached line finished without waitrequest", t_name[t]);
        test_errs++;
      end
    end
    report_test(t_name[t]);
  endtask

  task automatic build_table();
    add_test("a_rd_miss",     OP_AR,  32'h0000_1004, 32'h0, 32'h0, 4'h0, 1'b0);
    add_test("a_rd_hit",      OP_AR,  32'h0000_1008, 32'h0, 32'h0, 4'h0, 1'b1);
    add_test("a_wr_full",     OP_AW,  32'h0000_1010, 32'h0, 32'h1122_3344, 4'hf, 1'b1);
    add_test("a_wr_part",     OP_AW,  32'h0000_1010, 32'h0, 32'hAABB_CCDD, 4'h5, 1'b1);
    add_test("a_rd_merge",    OP_AR,  32'h0000_1010, 32'h0, 32'h0, 4'h0, 1'b1);
    add_test("b_rd_merge",    OP_BR,  32'h0, 32'h0000_1010, 32'h0, 4'h0, 1'b1);
    add_test("a_wr_byte",     OP_AW,  32'h0000_103C, 32'h0, 32'hDEAD_BEEF, 4'h8, 1'b1);
    add_test("a_rd_evict",    OP_AR,  32'h0010_1000, 32'h0, 32'h0, 4'h0, 1'b0);
    add_test("a_rd_back",     OP_AR,  32'h0000_1010, 32'h0, 32'h0, 4'h0, 1'b0);
    add_test("b_rd_back",     OP_BR,  32'h0, 32'h0000_103C, 32'h0, 4'h0, 1'b1);
    add_test("a_wr_miss",     OP_AW,  32'h0000_2084, 32'h0, 32'h55AA_1234, 4'h3, 1'b0);
    add_test("ab_rd_miss",    OP_ABR, 32'h0000_30C0, 32'h0000_4100, 32'h0, 4'h0, 1'b0);
    add_test("ab_rd_hit",     OP_ABR, 32'h0000_30C4, 32'h0000_4104, 32'h0, 4'h0, 1'b1);
    add_test("a_rd_conflict", OP_AR,  32'h0020_2080, 32'h0, 32'h0, 4'h0, 1'b0);
    add_test("b_rd_wb",       OP_BR,  32'h0, 32'h0000_2084, 32'h0, 4'h0, 1'b0);
    add_test("ab_same_line",  OP_ABR, 32'h0000_5000, 32'h0000_5008, 32'h0, 4'h0, 1'b0);
    add_test("a_wr_line0",    OP_AW,  32'h0000_5008, 32'h0, 32'h0BAD_F00D, 4'hf, 1'b1);
    add_test("ab_dirty_pair", OP_ABR, 32'h0030_5000, 32'h0000_6080, 32'h0, 4'h0, 1'b0);
    add_test("a_rd_final",    OP_AR,  32'h0000_5008, 32'h0, 32'h0, 4'h0, 1'b0);
  endtask

  initial begin
    rst_n        = 1'b0;
    a_address    = '0;
    a_read       = 1'b0;
    a_write      = 1'b0;
    a_writedata  = '0;
    a_byteenable = 4'h0;
    b_address    = '0;
    b_read       = 1'b0;
    build_table();
    cycle_limit = t_name.size() * CYCLES_PER_TEST;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    #1;
    check_reset_state();
    @(negedge clk);
    for (int t = 0; t < t_name.size(); t++) begin
      run_test(t);
    end
    $display("summary: %0d tests, %0d passed, %0d failed, %0d bus errors",
             n_pass + n_fail, n_pass, n_fail, bus_errs);
    if (n_fail == 0 && bus_errs == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== list.f ====
src/cache_pkg.sv
src/cache_line.sv
src/cache_refill.sv
src/cache_top.sv
dv/mem_model.sv
dv/tb_cache.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f list.f --top-module tb_cache -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_cache)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Test passed"; then
  exit 0
fi
exit 1
